// File: compile.f
+incdir+src
src/ex_data_pkg.sv
src/ex_op_pkg.sv
src/ex_issue_stage.sv
src/ex_alu.sv
src/ex_mul.sv
src/ex_writeback_stage.sv
src/ex_pipe_top.sv
tests/tb_ex_pipe.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_ex_pipe -o tb_ex_pipe

out=$(./obj_dir/tb_ex_pipe)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: src/ex_alu.sv
// execute alu: logic, shift, add/sub, compare, leading counts, overflow and trap checks
`include "ex_cfg.svh"

module ex_alu (
    input  ex_op_pkg::alu_op_t  i_alu_op,
    input  ex_data_pkg::word_t  i_op0,
    input  ex_data_pkg::word_t  i_op1,

    output ex_data_pkg::word_t  o_logic_res,
    output ex_data_pkg::word_t  o_shift_res,
    output ex_data_pkg::word_t  o_arith_res,
    output logic                o_overflow,
    output logic                o_trap
);

localparam int MSB = `EX_REG_W - 1;

logic                     do_sub;    // adder subtracts op1
ex_data_pkg::word_t       op1_add;   // op1 as seen by the adder
logic [`EX_REG_W:0]       sum_ext;   // sum with carry out
ex_data_pkg::word_t       sum;
logic                     carry;
logic                     lt_s;      // op0 < op1, signed
logic                     lt_u;      // op0 < op1, unsigned
logic [`EX_SHAMT_W-1:0]   shamt;
ex_data_pkg::word_t       lead_src;  // ones to count from the top
ex_data_pkg::bit_count_t  lead_cnt;
logic                     lead_run;

// subtract for sub/subu, the compares and the ordered traps
always_comb begin
    case (i_alu_op)
        ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU,
        ex_op_pkg::OP_SLT, ex_op_pkg::OP_SLTU,
        ex_op_pkg::OP_TGE, ex_op_pkg::OP_TGEU,
        ex_op_pkg::OP_TLT, ex_op_pkg::OP_TLTU: do_sub = 1'b1;
        default:                               do_sub = 1'b0;
    endcase
end

// single adder, a - b done as a + ~b + 1
assign op1_add = do_sub ? ~i_op1 : i_op1;
assign sum_ext = {1'b0, i_op0} + {1'b0, op1_add} + {{`EX_REG_W{1'b0}}, do_sub};
assign sum     = sum_ext[MSB:0];
assign carry   = sum_ext[`EX_REG_W];  // no borrow when subtracting

// signs differ: op0 negative wins, else sign of the difference
assign lt_s = (i_op0[MSB] & ~i_op1[MSB]) | (~(i_op0[MSB] ^ i_op1[MSB]) & sum[MSB]);
assign lt_u = ~carry;

// signed overflow, only add and sub raise it
always_comb begin
    o_overflow = 1'b0;
    if (i_alu_op == ex_op_pkg::OP_ADD || i_alu_op == ex_op_pkg::OP_SUB) begin
        o_overflow = (i_op0[MSB] == op1_add[MSB]) && (sum[MSB] != i_op0[MSB]);
    end
end

// trap conditions
always_comb begin
    case (i_alu_op)
        ex_op_pkg::OP_TEQ:  o_trap = (i_op0 == i_op1);
        ex_op_pkg::OP_TNE:  o_trap = (i_op0 != i_op1);
        ex_op_pkg::OP_TGE:  o_trap = ~lt_s;
        ex_op_pkg::OP_TGEU: o_trap = ~lt_u;
        ex_op_pkg::OP_TLT:  o_trap = lt_s;
        ex_op_pkg::OP_TLTU: o_trap = lt_u;
        default:            o_trap = 1'b0;
    endcase
end

// clz counts leading ones of the inverted word
assign lead_src = (i_alu_op == ex_op_pkg::OP_CLZ) ? ~i_op0 : i_op0;

always_comb begin
    lead_cnt = '0;
    lead_run = 1'b1;
    for (int i = MSB; i >= 0; i--) begin
        if (lead_run && lead_src[i]) begin
            lead_cnt = lead_cnt + 1'b1;
        end else begin
            lead_run = 1'b0;  // first mismatch ends the run
        end
    end
end

always_comb begin
    case (i_alu_op)
        ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU,
        ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU: o_arith_res = sum;
        ex_op_pkg::OP_SLT:  o_arith_res = ex_data_pkg::word_t'(lt_s);
        ex_op_pkg::OP_SLTU: o_arith_res = ex_data_pkg::word_t'(lt_u);
        ex_op_pkg::OP_CLZ, ex_op_pkg::OP_CLO:  o_arith_res = ex_data_pkg::word_t'(lead_cnt);
        default:            o_arith_res = '0;
    endcase
end

always_comb begin
    case (i_alu_op)
        ex_op_pkg::OP_OR:  o_logic_res = i_op0 | i_op1;
        ex_op_pkg::OP_AND: o_logic_res = i_op0 & i_op1;
        ex_op_pkg::OP_NOR: o_logic_res = ~(i_op0 | i_op1);
        ex_op_pkg::OP_XOR: o_logic_res = i_op0 ^ i_op1;
        default:           o_logic_res = '0;
    endcase
end

// op0 holds the amount, op1 the value
assign shamt = i_op0[`EX_SHAMT_W-1:0];

always_comb begin
    case (i_alu_op)
        ex_op_pkg::OP_SLL: o_shift_res = i_op1 << shamt;
        ex_op_pkg::OP_SRL: o_shift_res = i_op1 >> shamt;
        ex_op_pkg::OP_SRA: o_shift_res = $signed(i_op1) >>> shamt;  // sign fill
        default:           o_shift_res = '0;
    endcase
end

endmodule

// File: src/ex_cfg.svh
// execute unit configuration: datapath, register-address, shift and op-code widths
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data word width
`define EX_REG_W      32

// register file address width
`define EX_REG_ADDR_W 5

// shift amount, low bits of op0
`define EX_SHAMT_W    5

// op code width
`define EX_OP_W       8

`endif

// File: src/ex_data_pkg.sv
// execute datapath types: words, double words, register addresses and bit counts
`include "ex_cfg.svh"

package ex_data_pkg;

    // one data word
    typedef logic [`EX_REG_W-1:0] word_t;

    // hi/lo pair or full product
    typedef logic [2*`EX_REG_W-1:0] dword_t;

    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;  // destination register

    // leading bit count, 0 up to 32 inclusive
    typedef logic [$clog2(`EX_REG_W):0] bit_count_t;

endpackage

// File: src/ex_issue_stage.sv
// execute issue stage: registers the incoming op and operands, decodes the result class
module ex_issue_stage (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  ex_op_pkg::alu_op_t      i_alu_op,
    input  ex_data_pkg::word_t      i_op0,
    input  ex_data_pkg::word_t      i_op1,
    input  logic                    i_reg_wen,
    input  ex_data_pkg::reg_addr_t  i_reg_waddr,

    output logic                    o_valid,
    output ex_op_pkg::alu_op_t      o_alu_op,
    output ex_data_pkg::word_t      o_op0,
    output ex_data_pkg::word_t      o_op1,
    output logic                    o_reg_wen,
    output ex_data_pkg::reg_addr_t  o_reg_waddr,
    output ex_op_pkg::res_sel_t     o_res_sel
);

ex_op_pkg::res_sel_t res_sel;  // decoded class of the incoming op

// result class decode, stands in for the select code from decode
always_comb begin
    case (i_alu_op)
        ex_op_pkg::OP_OR, ex_op_pkg::OP_AND,
        ex_op_pkg::OP_NOR, ex_op_pkg::OP_XOR: res_sel = ex_op_pkg::RES_LOGIC;
        ex_op_pkg::OP_SLL, ex_op_pkg::OP_SRL,
        ex_op_pkg::OP_SRA:                    res_sel = ex_op_pkg::RES_SHIFT;
        ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU,
        ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU,
        ex_op_pkg::OP_SLT, ex_op_pkg::OP_SLTU,
        ex_op_pkg::OP_CLZ, ex_op_pkg::OP_CLO: res_sel = ex_op_pkg::RES_ARITH;
        ex_op_pkg::OP_MUL:                    res_sel = ex_op_pkg::RES_MUL;
        ex_op_pkg::OP_MFHI, ex_op_pkg::OP_MFLO: res_sel = ex_op_pkg::RES_MOVE;
        // mult, mthi/mtlo, traps and nop write no register
        default:                              res_sel = ex_op_pkg::RES_NONE;
    endcase
end

// control part
always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_valid   <= 1'b0;
        o_reg_wen <= 1'b0;
    end else begin
        o_valid   <= i_valid;
        o_reg_wen <= i_valid & i_reg_wen;
    end
end

// payload, follows the valid strobe
always_ff @(posedge i_clk) begin
    o_alu_op    <= i_alu_op;
    o_op0       <= i_op0;
    o_op1       <= i_op1;
    o_reg_waddr <= i_reg_waddr;
    o_res_sel   <= res_sel;
end

endmodule

// File: src/ex_mul.sv
// execute multiplier: 32x32 signed or unsigned product by magnitude and sign fix
module ex_mul (
    input  ex_op_pkg::alu_op_t   i_alu_op,
    input  ex_data_pkg::word_t   i_op0,
    input  ex_data_pkg::word_t   i_op1,

    output ex_data_pkg::dword_t  o_product
);

logic                 is_signed;  // mul and mult
logic                 neg0;
logic                 neg1;
ex_data_pkg::word_t   mag0;
ex_data_pkg::word_t   mag1;
ex_data_pkg::dword_t  prod_mag;

assign is_signed = (i_alu_op == ex_op_pkg::OP_MUL) || (i_alu_op == ex_op_pkg::OP_MULT);
assign neg0      = is_signed & i_op0[$high(i_op0)];
assign neg1      = is_signed & i_op1[$high(i_op1)];

// magnitudes, two's complement when negative
assign mag0 = neg0 ? (~i_op0 + 1'b1) : i_op0;
assign mag1 = neg1 ? (~i_op1 + 1'b1) : i_op1;

assign prod_mag = ex_data_pkg::dword_t'(mag0) * ex_data_pkg::dword_t'(mag1);

// signs differ -> negate the full product
assign o_product = (neg0 ^ neg1) ? (~prod_mag + 1'b1) : prod_mag;

endmodule

// File: src/ex_op_pkg.sv
// execute operation encodings: op codes and result-select classes
`include "ex_cfg.svh"

package ex_op_pkg;

    typedef enum logic [`EX_OP_W-1:0] {
        OP_NOP   = 8'h00,
        // logic
        OP_OR    = 8'h25,
        OP_AND   = 8'h24,
        OP_NOR   = 8'h27,
        OP_XOR   = 8'h26,
        // shifts
        OP_SLL   = 8'h7c,
        OP_SRL   = 8'h02,
        OP_SRA   = 8'h03,
        // add / sub / compare
        OP_ADD   = 8'h20,
        OP_ADDU  = 8'h21,
        OP_SUB   = 8'h22,
        OP_SUBU  = 8'h23,
        OP_SLT   = 8'h2a,
        OP_SLTU  = 8'h2b,
        OP_CLZ   = 8'hb0,
        OP_CLO   = 8'hb1,
        // multiply
        OP_MUL   = 8'ha9,
        OP_MULT  = 8'h18,
        OP_MULTU = 8'h19,
        // hi/lo moves
        OP_MFHI  = 8'h10,
        OP_MFLO  = 8'h12,
        OP_MTHI  = 8'h11,
        OP_MTLO  = 8'h13,
        // register traps
        OP_TEQ   = 8'h34,
        OP_TNE   = 8'h36,
        OP_TGE   = 8'h30,
        OP_TGEU  = 8'h31,
        OP_TLT   = 8'h32,
        OP_TLTU  = 8'h33
    } alu_op_t;

    // which unit supplies the register write data
    typedef enum logic [2:0] {
        RES_NONE  = 3'd0,
        RES_LOGIC = 3'd1,
        RES_SHIFT = 3'd2,
        RES_ARITH = 3'd3,
        RES_MUL   = 3'd4,
        RES_MOVE  = 3'd5
    } res_sel_t;

endpackage

// File: src/ex_pipe_top.sv
// execute pipeline top: issue register, alu and multiplier, writeback register
module ex_pipe_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  ex_op_pkg::alu_op_t      i_alu_op,
    input  ex_data_pkg::word_t      i_op0,
    input  ex_data_pkg::word_t      i_op1,
    input  logic                    i_reg_wen,
    input  ex_data_pkg::reg_addr_t  i_reg_waddr,

    output logic                    o_valid,
    output logic                    o_reg_wen,
    output ex_data_pkg::reg_addr_t  o_reg_waddr,
    output ex_data_pkg::word_t      o_reg_wdata,
    output logic                    o_ov_except,
    output logic                    o_trap_except,
    output ex_data_pkg::word_t      o_hi,
    output ex_data_pkg::word_t      o_lo
);

// issue stage outputs
logic                    s1_valid;
ex_op_pkg::alu_op_t      s1_op;
ex_data_pkg::word_t      s1_op0;
ex_data_pkg::word_t      s1_op1;
logic                    s1_wen;
ex_data_pkg::reg_addr_t  s1_waddr;
ex_op_pkg::res_sel_t     s1_sel;

// execute results, combinational
ex_data_pkg::word_t      alu_logic;
ex_data_pkg::word_t      alu_shift;
ex_data_pkg::word_t      alu_arith;
logic                    alu_ov;
logic                    alu_trap;
ex_data_pkg::dword_t     mul_product;

ex_issue_stage u_issue (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_alu_op    (i_alu_op),
    .i_op0       (i_op0),
    .i_op1       (i_op1),
    .i_reg_wen   (i_reg_wen),
    .i_reg_waddr (i_reg_waddr),
    .o_valid     (s1_valid),
    .o_alu_op    (s1_op),
    .o_op0       (s1_op0),
    .o_op1       (s1_op1),
    .o_reg_wen   (s1_wen),
    .o_reg_waddr (s1_waddr),
    .o_res_sel   (s1_sel)
);

ex_alu u_alu (
    .i_alu_op    (s1_op),
    .i_op0       (s1_op0),
    .i_op1       (s1_op1),
    .o_logic_res (alu_logic),
    .o_shift_res (alu_shift),
    .o_arith_res (alu_arith),
    .o_overflow  (alu_ov),
    .o_trap      (alu_trap)
);

ex_mul u_mul (
    .i_alu_op  (s1_op),
    .i_op0     (s1_op0),
    .i_op1     (s1_op1),
    .o_product (mul_product)
);

ex_writeback_stage u_wb (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (s1_valid),
    .i_alu_op      (s1_op),
    .i_res_sel     (s1_sel),
    .i_op0         (s1_op0),
    .i_reg_wen     (s1_wen),
    .i_reg_waddr   (s1_waddr),
    .i_logic_res   (alu_logic),
    .i_shift_res   (alu_shift),
    .i_arith_res   (alu_arith),
    .i_overflow    (alu_ov),
    .i_trap        (alu_trap),
    .i_product     (mul_product),
    .o_valid       (o_valid),
    .o_reg_wen     (o_reg_wen),
    .o_reg_waddr   (o_reg_waddr),
    .o_reg_wdata   (o_reg_wdata),
    .o_ov_except   (o_ov_except),
    .o_trap_except (o_trap_except),
    .o_hi          (o_hi),
    .o_lo          (o_lo)
);

endmodule

// File: src/ex_writeback_stage.sv
// execute writeback stage: result select, output registers and the hi/lo register
module ex_writeback_stage (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  ex_op_pkg::alu_op_t      i_alu_op,
    input  ex_op_pkg::res_sel_t     i_res_sel,
    input  ex_data_pkg::word_t      i_op0,
    input  logic                    i_reg_wen,
    input  ex_data_pkg::reg_addr_t  i_reg_waddr,
    input  ex_data_pkg::word_t      i_logic_res,
    input  ex_data_pkg::word_t      i_shift_res,
    input  ex_data_pkg::word_t      i_arith_res,
    input  logic                    i_overflow,
    input  logic                    i_trap,
    input  ex_data_pkg::dword_t     i_product,

    output logic                    o_valid,
    output logic                    o_reg_wen,
    output ex_data_pkg::reg_addr_t  o_reg_waddr,
    output ex_data_pkg::word_t      o_reg_wdata,
    output logic                    o_ov_except,
    output logic                    o_trap_except,
    output ex_data_pkg::word_t      o_hi,
    output ex_data_pkg::word_t      o_lo
);

ex_data_pkg::word_t move_res;  // mfhi / mflo value
ex_data_pkg::word_t wdata;

// hi/lo is read straight from the register, writes land before the next op reads
always_comb begin
    case (i_alu_op)
        ex_op_pkg::OP_MFHI: move_res = o_hi;
        ex_op_pkg::OP_MFLO: move_res = o_lo;
        default:            move_res = '0;
    endcase
end

always_comb begin
    case (i_res_sel)
        ex_op_pkg::RES_LOGIC: wdata = i_logic_res;
        ex_op_pkg::RES_SHIFT: wdata = i_shift_res;
        ex_op_pkg::RES_ARITH: wdata = i_arith_res;
        ex_op_pkg::RES_MUL:   wdata = i_product[$bits(ex_data_pkg::word_t)-1:0];  // low word
        ex_op_pkg::RES_MOVE:  wdata = move_res;
        default:              wdata = '0;
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_valid       <= 1'b0;
        o_reg_wen     <= 1'b0;
        o_ov_except   <= 1'b0;
        o_trap_except <= 1'b0;
    end else begin
        o_valid       <= i_valid;
        o_reg_wen     <= i_valid & i_reg_wen & ~i_overflow;  // overflow cancels the write
        o_ov_except   <= i_valid & i_overflow;
        o_trap_except <= i_valid & i_trap;
    end
end

always_ff @(posedge i_clk) begin
    o_reg_waddr <= i_reg_waddr;
    o_reg_wdata <= wdata;
end

// hi/lo register, committed with the op's o_valid
always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_hi <= '0;
        o_lo <= '0;
    end else if (i_valid) begin
        case (i_alu_op)
            ex_op_pkg::OP_MULT, ex_op_pkg::OP_MULTU: {o_hi, o_lo} <= i_product;
            ex_op_pkg::OP_MTHI: o_hi <= i_op0;
            ex_op_pkg::OP_MTLO: o_lo <= i_op0;
            default: ;
        endcase
    end
end

endmodule

// File: tests/tb_ex_pipe.sv
// execute pipeline testbench with directed op tests against a reference model
module tb_ex_pipe;

localparam int LATENCY    = 2;
localparam int MAX_CYCLES = 400;  // tests need about 120 cycles

typedef struct {
    logic                    wen;
    ex_data_pkg::reg_addr_t  waddr;
    ex_data_pkg::word_t      wdata;
    logic                    ov;
    logic                    trap;
    ex_data_pkg::word_t      hi;
    ex_data_pkg::word_t      lo;
    int                      due;  // cycle the result must show up
} exp_t;

logic                    clk;
logic                    rst;
logic                    valid;
ex_op_pkg::alu_op_t      alu_op;
ex_data_pkg::word_t      op0;
ex_data_pkg::word_t      op1;
logic                    reg_wen;
ex_data_pkg::reg_addr_t  reg_waddr;
logic                    o_valid;
logic                    o_reg_wen;
ex_data_pkg::reg_addr_t  o_reg_waddr;
ex_data_pkg::word_t      o_reg_wdata;
logic                    o_ov_except;
logic                    o_trap_except;
ex_data_pkg::word_t      o_hi;
ex_data_pkg::word_t      o_lo;

int                      seed = 32'h58c57aa2;
int                      cycle = 0;
int                      err_cnt = 0;
int                      test_cnt = 0;
int                      pass_cnt = 0;
exp_t                    exp_q[$];
ex_data_pkg::word_t      m_hi = '0;  // model hi/lo
ex_data_pkg::word_t      m_lo = '0;
ex_data_pkg::reg_addr_t  next_addr = '0;

ex_pipe_top dut0 (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_valid       (valid),
    .i_alu_op      (alu_op),
    .i_op0         (op0),
    .i_op1         (op1),
    .i_reg_wen     (reg_wen),
    .i_reg_waddr   (reg_waddr),
    .o_valid       (o_valid),
    .o_reg_wen     (o_reg_wen),
    .o_reg_waddr   (o_reg_waddr),
    .o_reg_wdata   (o_reg_wdata),
    .o_ov_except   (o_ov_except),
    .o_trap_except (o_trap_except),
    .o_hi          (o_hi),
    .o_lo          (o_lo)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end
end

function automatic ex_data_pkg::word_t rand_word();
    return ex_data_pkg::word_t'($random(seed));
endfunction

task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act === exp) else begin
        $display("Fail at %0t: %s = %h, expected %h", $time, name, act, exp);
        err_cnt++;
    end
endtask

// reference model that tracks hi/lo in issue order
function automatic exp_t model_op(input ex_op_pkg::alu_op_t op, input ex_data_pkg::word_t a,
                                  input ex_data_pkg::word_t b, input logic wen,
                                  input ex_data_pkg::reg_addr_t waddr);
    exp_t        e;
    longint      sum;  // exact signed result
    longint      prod;
    logic [63:0] uprod;
    int          s;
    s = int'(a[4:0]);
    e.wdata = '0;
    e.ov = 1'b0;
    e.trap = 1'b0;
    case (op)
        ex_op_pkg::OP_OR:  e.wdata = a | b;
        ex_op_pkg::OP_AND: e.wdata = a & b;
        ex_op_pkg::OP_NOR: e.wdata = ~(a | b);
        ex_op_pkg::OP_XOR: e.wdata = a ^ b;
        ex_op_pkg::OP_SLL: e.wdata = b << s;
        ex_op_pkg::OP_SRL: e.wdata = b >> s;
        ex_op_pkg::OP_SRA: e.wdata = (b >> s) | (b[31] ? ~(32'hffff_ffff >> s) : 32'h0);
        ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU, ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU: begin
            if (op == ex_op_pkg::OP_ADD || op == ex_op_pkg::OP_ADDU)
                sum = longint'($signed(a)) + longint'($signed(b));
            else
                sum = longint'($signed(a)) - longint'($signed(b));
            e.wdata = sum[31:0];
            e.ov = (op == ex_op_pkg::OP_ADD || op == ex_op_pkg::OP_SUB) &&
                   (sum > 64'sd2147483647 || sum < -64'sd2147483648);
        end
        ex_op_pkg::OP_SLT:  e.wdata = {31'b0, $signed(a) < $signed(b)};
        ex_op_pkg::OP_SLTU: e.wdata = {31'b0, a < b};
        ex_op_pkg::OP_CLZ, ex_op_pkg::OP_CLO: begin
            for (int i = 31; i >= 0 && a[i] == (op == ex_op_pkg::OP_CLO); i--)
                e.wdata++;
        end
        ex_op_pkg::OP_MUL: begin
            prod = longint'($signed(a)) * longint'($signed(b));
            e.wdata = prod[31:0];
        end
        ex_op_pkg::OP_MULT: begin
            prod = longint'($signed(a)) * longint'($signed(b));
            {m_hi, m_lo} = prod;
        end
        ex_op_pkg::OP_MULTU: begin
            uprod = {32'h0, a} * {32'h0, b};
            {m_hi, m_lo} = uprod;
        end
        ex_op_pkg::OP_MFHI: e.wdata = m_hi;
        ex_op_pkg::OP_MFLO: e.wdata = m_lo;
        ex_op_pkg::OP_MTHI: m_hi = a;
        ex_op_pkg::OP_MTLO: m_lo = a;
        ex_op_pkg::OP_TEQ:  e.trap = (a == b);
        ex_op_pkg::OP_TNE:  e.trap = (a != b);
        ex_op_pkg::OP_TGE:  e.trap = ($signed(a) >= $signed(b));
        ex_op_pkg::OP_TGEU: e.trap = (a >= b);
        ex_op_pkg::OP_TLT:  e.trap = ($signed(a) < $signed(b));
        ex_op_pkg::OP_TLTU: e.trap = (a < b);
        default: ;
    endcase
    e.wen = wen & ~e.ov;
    e.waddr = waddr;
    e.hi = m_hi;
    e.lo = m_lo;
    return e;
endfunction

task automatic issue(input ex_op_pkg::alu_op_t op, input ex_data_pkg::word_t a,
                     input ex_data_pkg::word_t b, input logic wen);
    exp_t e;
    @(posedge clk);
    valid     <= 1'b1;
    alu_op    <= op;
    op0       <= a;
    op1       <= b;
    reg_wen   <= wen;
    reg_waddr <= next_addr;
    e = model_op(op, a, b, wen, next_addr);
    e.due = cycle + LATENCY + 1;  // one edge to sample then two stages
    exp_q.push_back(e);
    next_addr++;
endtask

// stop issuing and wait until every result came out
task automatic drain();
    @(posedge clk);
    valid   <= 1'b0;
    reg_wen <= 1'b0;
    alu_op  <= ex_op_pkg::OP_NOP;
    while (exp_q.size() != 0)
        @(posedge clk);
endtask

task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before)
        pass_cnt++;
    $display("%-14s %s", name, (err_cnt == errs_before) ? "ok" : "failed");
endtask

// output monitor comparing every result with the queued expectation
always @(negedge clk) begin
    exp_t e;
    if (!rst && o_valid) begin
        if (exp_q.size() == 0) begin
            $display("Error at %0t: o_valid high with no op in flight", $time);
            err_cnt++;
        end else begin
            e = exp_q.pop_front();
            check_val("latency cycle", cycle, e.due);
            check_val("o_reg_wen", o_reg_wen, e.wen);
            check_val("o_reg_waddr", o_reg_waddr, e.waddr);
            check_val("o_reg_wdata", o_reg_wdata, e.wdata);
            check_val("o_ov_except", o_ov_except, e.ov);
            check_val("o_trap_except", o_trap_except, e.trap);
            check_val("o_hi", o_hi, e.hi);
            check_val("o_lo", o_lo, e.lo);
        end
    end else if (!rst) begin
        check_val("o_reg_wen", o_reg_wen, 1'b0);  // idle slot
        check_val("o_ov_except", o_ov_except, 1'b0);
        check_val("o_trap_except", o_trap_except, 1'b0);
        if (exp_q.size() != 0 && cycle > exp_q[0].due) begin
            $display("Error at %0t: result due in cycle %0d never came out", $time, exp_q[0].due);
            err_cnt++;
            void'(exp_q.pop_front());
        end
    end
end

task automatic logic_shift_test();
    int e0;
    e0 = err_cnt;
    issue(ex_op_pkg::OP_OR, rand_word(), rand_word(), 1'b1);
    issue(ex_op_pkg::OP_AND, rand_word(), rand_word(), 1'b1);
    issue(ex_op_pkg::OP_NOR, rand_word(), rand_word(), 1'b0);
    issue(ex_op_pkg::OP_XOR, rand_word(), rand_word(), 1'b1);
    issue(ex_op_pkg::OP_SLL, 32'h0000_0024, 32'h8000_00f1, 1'b1);  // only low 5 bits count
    issue(ex_op_pkg::OP_SRL, 32'h0000_0007, 32'hf000_1234, 1'b1);
    issue(ex_op_pkg::OP_SRA, 32'h0000_0004, 32'h8000_1234, 1'b1);
    issue(ex_op_pkg::OP_SRA, 32'h0000_001f, 32'h7fff_ffff, 1'b1);
    issue(ex_op_pkg::OP_SRA, rand_word(), rand_word(), 1'b1);
    drain();
    report_test("logic_shift", e0);
endtask

task automatic arith_test();
    int e0;
    e0 = err_cnt;
    issue(ex_op_pkg::OP_ADD, 32'd5, 32'd7, 1'b1);
    issue(ex_op_pkg::OP_ADD, 32'h7fff_ffff, 32'd1, 1'b1);  // overflow
    issue(ex_op_pkg::OP_ADDU, 32'h7fff_ffff, 32'd1, 1'b1);
    issue(ex_op_pkg::OP_SUB, 32'h8000_0000, 32'd1, 1'b1);  // overflow
    issue(ex_op_pkg::OP_SUBU, 32'h8000_0000, 32'd1, 1'b1);
    issue(ex_op_pkg::OP_SUB, rand_word(), rand_word(), 1'b1);
    issue(ex_op_pkg::OP_SLT, 32'hffff_ffff, 32'd1, 1'b1);
    issue(ex_op_pkg::OP_SLTU, 32'hffff_ffff, 32'd1, 1'b1);
    issue(ex_op_pkg::OP_SLTU, 32'd1, 32'hffff_ffff, 1'b1);
    drain();
    report_test("arith", e0);
endtask

task automatic lead_count_test();
    int e0;
    e0 = err_cnt;
    issue(ex_op_pkg::OP_CLZ, 32'h0000_0000, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_CLZ, 32'hffff_ffff, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_CLZ, 32'h0001_0000, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_CLO, 32'hffff_ffff, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_CLO, 32'h0000_0000, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_CLO, 32'hf0ff_ffff, 32'h0, 1'b1);
    drain();
    report_test("lead_count", e0);
endtask

task automatic mul_hilo_test();
    int e0;
    e0 = err_cnt;
    issue(ex_op_pkg::OP_MUL, 32'hffff_fffd, 32'd7, 1'b1);
    issue(ex_op_pkg::OP_MULT, rand_word(), rand_word(), 1'b0);
    issue(ex_op_pkg::OP_MFHI, 32'h0, 32'h0, 1'b1);  // right behind the write
    issue(ex_op_pkg::OP_MFLO, 32'h0, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    issue(ex_op_pkg::OP_MFHI, 32'h0, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_MULT, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    issue(ex_op_pkg::OP_MTHI, rand_word(), 32'h0, 1'b0);
    issue(ex_op_pkg::OP_MFHI, 32'h0, 32'h0, 1'b1);
    issue(ex_op_pkg::OP_MTLO, rand_word(), 32'h0, 1'b0);
    issue(ex_op_pkg::OP_MFLO, 32'h0, 32'h0, 1'b1);
    drain();
    report_test("mul_hilo", e0);
endtask

task automatic trap_test();
    int e0;
    e0 = err_cnt;
    issue(ex_op_pkg::OP_TEQ, 32'd5, 32'd5, 1'b0);
    issue(ex_op_pkg::OP_TEQ, 32'd5, 32'd6, 1'b0);
    issue(ex_op_pkg::OP_TNE, 32'd5, 32'd6, 1'b0);
    issue(ex_op_pkg::OP_TNE, 32'd5, 32'd5, 1'b0);
    issue(ex_op_pkg::OP_TGE, 32'hffff_ffff, 32'd1, 1'b0);
    issue(ex_op_pkg::OP_TGEU, 32'hffff_ffff, 32'd1, 1'b0);
    issue(ex_op_pkg::OP_TGE, 32'd3, 32'd3, 1'b0);
    issue(ex_op_pkg::OP_TLT, 32'hffff_ffff, 32'd1, 1'b0);
    issue(ex_op_pkg::OP_TLTU, 32'hffff_ffff, 32'd1, 1'b0);
    issue(ex_op_pkg::OP_TLTU, 32'd0, 32'd1, 1'b0);
    issue(ex_op_pkg::OP_TGEU, 32'd0, 32'd1, 1'b0);
    drain();
    report_test("traps", e0);
endtask

task automatic stream_test();
    ex_op_pkg::alu_op_t mix[6];
    int                 e0;
    mix = '{ex_op_pkg::OP_OR, ex_op_pkg::OP_AND, ex_op_pkg::OP_XOR,
            ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU, ex_op_pkg::OP_SLT};
    e0 = err_cnt;
    repeat (20)
        issue(mix[rand_word() % 6], rand_word(), rand_word(), rand_word() % 2 == 0);
    drain();
    report_test("stream", e0);
endtask

task automatic reset_test();
    int e0;
    e0 = err_cnt;
    issue(ex_op_pkg::OP_MULTU, rand_word() | 32'h1, rand_word() | 32'h1, 1'b0);  // hi/lo nonzero
    drain();
    issue(ex_op_pkg::OP_TEQ, 32'd9, 32'd9, 1'b1);  // trap with a write, dropped by reset
    @(posedge clk);
    rst     <= 1'b1;
    valid   <= 1'b0;
    reg_wen <= 1'b0;
    alu_op  <= ex_op_pkg::OP_NOP;
    @(posedge clk);
    exp_q.delete();
    m_hi = '0;
    m_lo = '0;
    @(negedge clk);
    check_val("o_valid", o_valid, 1'b0);  // teq would sit in writeback here
    check_val("o_reg_wen", o_reg_wen, 1'b0);
    check_val("o_trap_except", o_trap_except, 1'b0);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_val("o_valid", o_valid, 1'b0);
    check_val("o_reg_wen", o_reg_wen, 1'b0);
    check_val("o_ov_except", o_ov_except, 1'b0);
    check_val("o_trap_except", o_trap_except, 1'b0);
    check_val("o_hi", o_hi, 32'h0);
    check_val("o_lo", o_lo, 32'h0);
    report_test("reset", e0);
endtask

initial begin
    rst       = 1'b1;
    valid     = 1'b0;
    alu_op    = ex_op_pkg::OP_NOP;
    op0       = '0;
    op1       = '0;
    reg_wen   = 1'b0;
    reg_waddr = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    logic_shift_test();
    arith_test();
    lead_count_test();
    mul_hilo_test();
    trap_test();
    stream_test();
    reset_test();
    $display("tests run %0d, passed %0d, failed checks %0d", test_cnt, pass_cnt, err_cnt);
    if (err_cnt == 0) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule
